/* Makefile */
# Verilator simulation of the DMA front end

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench, fails unless the log holds the pass line"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module dma_fe_tb -Mdir obj_dir
	./obj_dir/Vdma_fe_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "Test OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* flist.f */
+incdir+source
source/dma_fe_pkg.sv
source/dma_cmd_decode.sv
source/dma_twod_expand.sv
source/dma_beat_gen.sv
source/dma_id_tracker.sv
source/dma_resp_spill.sv
source/dma_fe_top.sv
verif/dma_fe_tb.sv

/* source/dma_beat_gen.sv */
// --------------------------------------------------
// beat generator: splits a row into beats of up to
// DMA_BEAT_BYTES and flags row completion
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_beat_gen (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  dma_fe_pkg::dma_row_req_t row_i,
    input  logic                     row_valid_i,
    output logic                     row_ready_o,
    output dma_fe_pkg::dma_beat_t    beat_o,
    output logic                     beat_valid_o,
    output logic                     row_done_o
);

    localparam int unsigned        LW   = $clog2(`DMA_BEAT_BYTES) + 1;
    localparam logic [`DMA_AW-1:0] STEP = `DMA_BEAT_BYTES;

    logic               busy_q;
    logic [`DMA_AW-1:0] left_q;
    logic [`DMA_AW-1:0] src_q;
    logic [`DMA_AW-1:0] dst_q;
    logic               take;
    logic               last_step;
    logic [LW-1:0]      len;

    assign row_ready_o = !busy_q;
    assign take        = row_valid_i && !busy_q;

    // final beat carries the remainder
    assign last_step    = (left_q <= STEP);
    assign len          = last_step ? left_q[LW-1:0] : STEP[LW-1:0];
    assign beat_valid_o = busy_q && (left_q != '0);
    // zero-byte rows finish without a beat
    assign row_done_o   = busy_q && last_step;

    always_comb begin
        beat_o.src = src_q;
        beat_o.dst = dst_q;
        beat_o.len = len;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
        if (!rst_ni) begin
            busy_q <= 1'b0;
            left_q <= '0;
        end else if (take) begin
            busy_q <= 1'b1;
            left_q <= row_i.num_bytes;
        end else if (busy_q) begin
            left_q <= left_q - {{(`DMA_AW-LW){1'b0}}, len};
            if (last_step) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin : proc_addr
        if (take) begin
            src_q <= row_i.src;
            dst_q <= row_i.dst;
        end else if (beat_valid_o) begin
            src_q <= src_q + STEP;
            dst_q <= dst_q + STEP;
        end
    end

endmodule

/* source/dma_cmd_decode.sv */
// --------------------------------------------------
// instruction decode stage: configuration registers,
// transfer start and status/start responses
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_cmd_decode (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  dma_fe_pkg::dma_acc_req_t  req_i,
    input  logic                      qvalid_i,
    output logic                      qready_o,
    input  logic [`DMA_IDW-1:0]       next_id_i,
    input  logic [`DMA_IDW-1:0]       completed_id_i,
    input  logic                      busy_i,
    output dma_fe_pkg::dma_twod_req_t twod_o,
    output logic                      twod_valid_o,
    input  logic                      twod_ready_i,
    output dma_fe_pkg::dma_acc_resp_t resp_o,
    output logic                      resp_valid_o,
    input  logic                      resp_ready_i
);

    logic [`DMA_AW-1:0] src_q;
    logic [`DMA_AW-1:0] dst_q;
    logic [`DMA_AW-1:0] stride_src_q;
    logic [`DMA_AW-1:0] stride_dst_q;
    logic [`DMA_AW-1:0] reps_q;
    logic               is_op;
    logic [6:0]         funct7;
    logic [1:0]         stat_sel;
    logic               start_twod;

    //------------------------------------------------
    // field extraction
    //------------------------------------------------
    assign funct7 = req_i.op.instr.funct7;
    assign is_op  = qvalid_i && (req_i.op.instr.opcode == `DMA_OPCODE)
                    && (req_i.op.instr.funct3 == 3'd0);

    // immediate forms read their config from the rs2 slot
    assign stat_sel   = (funct7 == `DMA_F7_STATI) ? req_i.op.imm.imm_cfg[1:0]
                                                  : req_i.arga[1:0];
    assign start_twod = (funct7 == `DMA_F7_STRTI) ? req_i.op.imm.imm_cfg[0]
                                                  : req_i.argb[0];

    // start request: held registers plus the byte count
    always_comb begin
        twod_o.src        = src_q;
        twod_o.dst        = dst_q;
        twod_o.num_bytes  = req_i.arga;
        twod_o.stride_src = stride_src_q;
        twod_o.stride_dst = stride_dst_q;
        twod_o.num_reps   = reps_q;
        twod_o.is_twod    = start_twod;
    end

    //------------------------------------------------
    // handshake and response
    //------------------------------------------------
    always_comb begin : proc_decode
        qready_o     = 1'b0;
        twod_valid_o = 1'b0;
        resp_valid_o = 1'b0;
        resp_o.tag   = req_i.tag;
        resp_o.data  = '0;
        if (is_op) begin
            case (funct7)
                `DMA_F7_SRC, `DMA_F7_DST, `DMA_F7_STRD, `DMA_F7_REPS: begin
                    qready_o = 1'b1;
                end
                `DMA_F7_STRTI, `DMA_F7_STRT: begin
                    // needs a response slot and a free expander
                    twod_valid_o = resp_ready_i;
                    qready_o     = resp_ready_i && twod_ready_i;
                    resp_valid_o = resp_ready_i && twod_ready_i;
                    resp_o.data  = {{(`DMA_DW-`DMA_IDW){1'b0}}, next_id_i};
                end
                `DMA_F7_STATI, `DMA_F7_STAT: begin
                    qready_o     = resp_ready_i;
                    resp_valid_o = resp_ready_i;
                    case (stat_sel)
                        `DMA_STAT_COMPLETED: begin
                            resp_o.data = {{(`DMA_DW-`DMA_IDW){1'b0}}, completed_id_i};
                        end
                        `DMA_STAT_NEXT: begin
                            resp_o.data = {{(`DMA_DW-`DMA_IDW){1'b0}}, next_id_i};
                        end
                        `DMA_STAT_BUSY: begin
                            resp_o.data = {{(`DMA_DW-1){1'b0}}, busy_i};
                        end
                        `DMA_STAT_FULL: begin
                            // start path cannot take another request
                            resp_o.data = {{(`DMA_DW-1){1'b0}}, !twod_ready_i};
                        end
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    //------------------------------------------------
    // configuration registers
    //------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cfg
        if (!rst_ni) begin
            src_q        <= '0;
            dst_q        <= '0;
            stride_src_q <= '0;
            stride_dst_q <= '0;
            reps_q       <= '0;
        end else if (is_op) begin
            case (funct7)
                `DMA_F7_SRC: src_q <= req_i.arga;
                `DMA_F7_DST: dst_q <= req_i.arga;
                `DMA_F7_STRD: begin
                    stride_src_q <= req_i.arga;
                    stride_dst_q <= req_i.argb;
                end
                `DMA_F7_REPS: reps_q <= req_i.arga;
                default: begin
                end
            endcase
        end
    end

endmodule

/* source/dma_fe_consts.svh */
// --------------------------------------------------
// widths, opcode and function codes, status
// selectors, beat size and last-row FIFO depth
// --------------------------------------------------

`ifndef DMA_FE_CONSTS_SVH
`define DMA_FE_CONSTS_SVH

// datapath widths
`define DMA_AW 32
`define DMA_DW 32
`define DMA_TAGW 5
`define DMA_IDW 16

// beat port and last-row FIFO
`define DMA_BEAT_BYTES 8
`define DMA_LAST_DEPTH 4

// custom-1 major opcode, function-3 is always zero
`define DMA_OPCODE 7'b0101011

// function-7 codes
`define DMA_F7_SRC 7'd0
`define DMA_F7_DST 7'd1
`define DMA_F7_STRTI 7'd2
`define DMA_F7_STRT 7'd3
`define DMA_F7_STATI 7'd4
`define DMA_F7_STAT 7'd5
`define DMA_F7_STRD 7'd6
`define DMA_F7_REPS 7'd7

// status selectors, shared by both status forms
`define DMA_STAT_COMPLETED 2'd0
`define DMA_STAT_NEXT 2'd1
`define DMA_STAT_BUSY 2'd2
`define DMA_STAT_FULL 2'd3

`endif

/* source/dma_fe_pkg.sv */
// --------------------------------------------------
// types of the DMA front end: operation word views,
// accelerator request/response and stage payloads
// --------------------------------------------------

`include "dma_fe_consts.svh"

package dma_fe_pkg;

    // standard R-type view of the operation word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } dma_instr_t;

    // immediate view, config bits sit in the rs2 slot
    typedef struct packed {
        logic [6:0]  funct7;
        logic [4:0]  imm_cfg;
        logic [19:0] rest;
    } dma_imm_op_t;

    typedef union packed {
        dma_instr_t  instr;
        dma_imm_op_t imm;
    } dma_op_u;

    typedef struct packed {
        dma_op_u               op;
        logic [`DMA_TAGW-1:0]  tag;
        logic [`DMA_DW-1:0]    arga;
        logic [`DMA_DW-1:0]    argb;
    } dma_acc_req_t;

    typedef struct packed {
        logic [`DMA_TAGW-1:0] tag;
        logic [`DMA_DW-1:0]   data;
    } dma_acc_resp_t;

    typedef struct packed {
        logic [`DMA_AW-1:0] src;
        logic [`DMA_AW-1:0] dst;
        logic [`DMA_AW-1:0] num_bytes;
        logic [`DMA_AW-1:0] stride_src;
        logic [`DMA_AW-1:0] stride_dst;
        logic [`DMA_AW-1:0] num_reps;
        logic               is_twod;
    } dma_twod_req_t;

    typedef struct packed {
        logic [`DMA_AW-1:0] src;
        logic [`DMA_AW-1:0] dst;
        logic [`DMA_AW-1:0] num_bytes;
        logic               last;
    } dma_row_req_t;

    typedef struct packed {
        logic [`DMA_AW-1:0]                 src;
        logic [`DMA_AW-1:0]                 dst;
        logic [$clog2(`DMA_BEAT_BYTES):0]   len;
    } dma_beat_t;

endpackage

/* source/dma_fe_top.sv */
// --------------------------------------------------
// DMA front end top level: decode, 2D expansion,
// beat generation, id tracking and response spill
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_fe_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  dma_fe_pkg::dma_acc_req_t  acc_req_i,
    input  logic                      acc_qvalid_i,
    output logic                      acc_qready_o,
    output dma_fe_pkg::dma_acc_resp_t acc_resp_o,
    output logic                      acc_pvalid_o,
    input  logic                      acc_pready_i,
    output dma_fe_pkg::dma_beat_t     beat_o,
    output logic                      beat_valid_o,
    output logic                      dma_busy_o
);

    dma_fe_pkg::dma_twod_req_t twod;
    logic                      twod_valid;
    logic                      twod_ready;
    dma_fe_pkg::dma_row_req_t  row;
    logic                      row_valid;
    logic                      row_ready;
    logic                      row_done;
    dma_fe_pkg::dma_acc_resp_t resp;
    logic                      resp_valid;
    logic                      resp_ready;
    logic [`DMA_IDW-1:0]       next_id;
    logic [`DMA_IDW-1:0]       completed_id;

    //------------------------------------------------
    // command path
    //------------------------------------------------
    dma_cmd_decode i_decode (
        .clk_i          ( clk_i        ),
        .rst_ni         ( rst_ni       ),
        .req_i          ( acc_req_i    ),
        .qvalid_i       ( acc_qvalid_i ),
        .qready_o       ( acc_qready_o ),
        .next_id_i      ( next_id      ),
        .completed_id_i ( completed_id ),
        .busy_i         ( dma_busy_o   ),
        .twod_o         ( twod         ),
        .twod_valid_o   ( twod_valid   ),
        .twod_ready_i   ( twod_ready   ),
        .resp_o         ( resp         ),
        .resp_valid_o   ( resp_valid   ),
        .resp_ready_i   ( resp_ready   )
    );

    dma_resp_spill i_spill (
        .clk_i   ( clk_i        ),
        .rst_ni  ( rst_ni       ),
        .valid_i ( resp_valid   ),
        .ready_o ( resp_ready   ),
        .data_i  ( resp         ),
        .valid_o ( acc_pvalid_o ),
        .ready_i ( acc_pready_i ),
        .data_o  ( acc_resp_o   )
    );

    //------------------------------------------------
    // transfer path
    //------------------------------------------------
    dma_twod_expand i_expand (
        .clk_i        ( clk_i      ),
        .rst_ni       ( rst_ni     ),
        .twod_i       ( twod       ),
        .twod_valid_i ( twod_valid ),
        .twod_ready_o ( twod_ready ),
        .row_o        ( row        ),
        .row_valid_o  ( row_valid  ),
        .row_ready_i  ( row_ready  )
    );

    dma_beat_gen i_beat_gen (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .row_i        ( row          ),
        .row_valid_i  ( row_valid    ),
        .row_ready_o  ( row_ready    ),
        .beat_o       ( beat_o       ),
        .beat_valid_o ( beat_valid_o ),
        .row_done_o   ( row_done     )
    );

    dma_id_tracker i_id_tracker (
        .clk_i          ( clk_i                    ),
        .rst_ni         ( rst_ni                   ),
        .issue_i        ( twod_valid && twod_ready ),
        .row_push_i     ( row_valid && row_ready   ),
        .row_last_i     ( row.last                 ),
        .row_done_i     ( row_done                 ),
        .next_id_o      ( next_id                  ),
        .completed_id_o ( completed_id             ),
        .busy_o         ( dma_busy_o               )
    );

endmodule

/* source/dma_id_tracker.sv */
// --------------------------------------------------
// transfer id tracking: issue/retire counters, FIFO
// of last-row flags and busy level
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_id_tracker (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                issue_i,
    input  logic                row_push_i,
    input  logic                row_last_i,
    input  logic                row_done_i,
    output logic [`DMA_IDW-1:0] next_id_o,
    output logic [`DMA_IDW-1:0] completed_id_o,
    output logic                busy_o
);

    localparam int unsigned PW = $clog2(`DMA_LAST_DEPTH);

    logic [`DMA_LAST_DEPTH-1:0] last_mem_q;
    logic [PW-1:0]              wr_ptr_q;
    logic [PW-1:0]              rd_ptr_q;
    logic [`DMA_IDW-1:0]        next_q;
    logic [`DMA_IDW-1:0]        comp_q;
    logic                       retire;

    // a transfer retires with the completion of its last row
    assign retire = row_done_i && last_mem_q[rd_ptr_q];

    assign next_id_o      = next_q;
    assign completed_id_o = comp_q;
    assign busy_o         = (next_q != comp_q);

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_cnt
        if (!rst_ni) begin
            next_q   <= '0;
            comp_q   <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (issue_i) begin
                next_q <= next_q + 1'b1;
            end
            if (retire) begin
                comp_q <= comp_q + 1'b1;
            end
            if (row_push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (row_done_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // flag storage
    always_ff @(posedge clk_i) begin : proc_mem
        if (row_push_i) begin
            last_mem_q[wr_ptr_q] <= row_last_i;
        end
    end

endmodule

/* source/dma_resp_spill.sv */
// --------------------------------------------------
// two-slot spill register on the response path
// --------------------------------------------------

`timescale 1ns/1ps

module dma_resp_spill (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      valid_i,
    output logic                      ready_o,
    input  dma_fe_pkg::dma_acc_resp_t data_i,
    output logic                      valid_o,
    input  logic                      ready_i,
    output dma_fe_pkg::dma_acc_resp_t data_o
);

    dma_fe_pkg::dma_acc_resp_t a_data_q;
    dma_fe_pkg::dma_acc_resp_t b_data_q;
    logic                      a_full_q;
    logic                      b_full_q;
    logic                      a_fill;
    logic                      a_drain;
    logic                      b_fill;
    logic                      b_drain;

    // slot b always holds the older entry
    assign a_fill  = valid_i && ready_o;
    assign a_drain = a_full_q && !b_full_q;
    assign b_fill  = a_drain && !ready_i;
    assign b_drain = b_full_q && ready_i;

    // ready only looks at state, never at ready_i
    assign ready_o = !a_full_q || !b_full_q;
    assign valid_o = a_full_q || b_full_q;
    assign data_o  = b_full_q ? b_data_q : a_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_full
        if (!rst_ni) begin
            a_full_q <= 1'b0;
            b_full_q <= 1'b0;
        end else begin
            a_full_q <= a_fill || (a_full_q && !a_drain);
            b_full_q <= b_fill || (b_full_q && !b_drain);
        end
    end

    always_ff @(posedge clk_i) begin : proc_data
        if (a_fill) begin
            a_data_q <= data_i;
        end
        if (b_fill) begin
            b_data_q <= a_data_q;
        end
    end

endmodule

/* source/dma_twod_expand.sv */
// --------------------------------------------------
// 2D expansion stage: one start request in, a series
// of strided row requests out
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_twod_expand (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  dma_fe_pkg::dma_twod_req_t twod_i,
    input  logic                      twod_valid_i,
    output logic                      twod_ready_o,
    output dma_fe_pkg::dma_row_req_t  row_o,
    output logic                      row_valid_o,
    input  logic                      row_ready_i
);

    localparam logic [`DMA_AW-1:0] ONE_ROW = 1;

    dma_fe_pkg::dma_twod_req_t req_q;
    logic                      busy_q;
    logic [`DMA_AW-1:0]        rows_left_q;
    logic [`DMA_AW-1:0]        num_rows;
    logic                      take;
    logic                      row_fire;
    logic                      last_row;

    // a 1D request or zero repetitions gives a single row
    assign num_rows = (twod_i.is_twod && (twod_i.num_reps != '0)) ? twod_i.num_reps
                                                                  : ONE_ROW;

    assign twod_ready_o = !busy_q;
    assign take         = twod_valid_i && !busy_q;
    assign row_valid_o  = busy_q;
    assign row_fire     = busy_q && row_ready_i;
    assign last_row     = (rows_left_q == ONE_ROW);

    always_comb begin
        row_o.src       = req_q.src;
        row_o.dst       = req_q.dst;
        row_o.num_bytes = req_q.num_bytes;
        row_o.last      = last_row;
    end

    // row counter and occupancy
    always_ff @(posedge clk_i or negedge rst_ni) begin : proc_ctrl
        if (!rst_ni) begin
            busy_q      <= 1'b0;
            rows_left_q <= '0;
        end else if (take) begin
            busy_q      <= 1'b1;
            rows_left_q <= num_rows;
        end else if (row_fire) begin
            rows_left_q <= rows_left_q - ONE_ROW;
            if (last_row) begin
                busy_q <= 1'b0;
            end
        end
    end

    // addresses step by the strides after each row
    always_ff @(posedge clk_i) begin : proc_req
        if (take) begin
            req_q <= twod_i;
        end else if (row_fire) begin
            req_q.src <= req_q.src + req_q.stride_src;
            req_q.dst <= req_q.dst + req_q.stride_dst;
        end
    end

endmodule

/* verif/dma_fe_tb.sv */
// --------------------------------------------------
// DMA front end testbench with clock, reset,
// accelerator stimulus, beat reference model and
// beat/response checkers
// --------------------------------------------------

`timescale 1ns/1ps
`include "dma_fe_consts.svh"

module dma_fe_tb;

    localparam int unsigned        TIMEOUT = 2000;
    localparam int unsigned        LW      = $clog2(`DMA_BEAT_BYTES) + 1;
    localparam logic [`DMA_AW-1:0] BEAT    = `DMA_BEAT_BYTES;

    logic                      clk_i;
    logic                      rst_ni;
    dma_fe_pkg::dma_acc_req_t  acc_req_i;
    logic                      acc_qvalid_i;
    logic                      acc_qready_o;
    dma_fe_pkg::dma_acc_resp_t acc_resp_o;
    logic                      acc_pvalid_o;
    logic                      acc_pready_i;
    dma_fe_pkg::dma_beat_t     beat_o;
    logic                      beat_valid_o;
    logic                      dma_busy_o;

    dma_fe_pkg::dma_beat_t     exp_beats[$];
    dma_fe_pkg::dma_acc_resp_t exp_resps[$];
    dma_fe_pkg::dma_acc_resp_t got_resps[$];
    // model of the configuration registers
    dma_fe_pkg::dma_twod_req_t cfg;
    logic [`DMA_IDW-1:0]       exp_id;
    string                     test_name;

    dma_fe_top dut (
        .clk_i        ( clk_i        ),
        .rst_ni       ( rst_ni       ),
        .acc_req_i    ( acc_req_i    ),
        .acc_qvalid_i ( acc_qvalid_i ),
        .acc_qready_o ( acc_qready_o ),
        .acc_resp_o   ( acc_resp_o   ),
        .acc_pvalid_o ( acc_pvalid_o ),
        .acc_pready_i ( acc_pready_i ),
        .beat_o       ( beat_o       ),
        .beat_valid_o ( beat_valid_o ),
        .dma_busy_o   ( dma_busy_o   )
    );

    always #2 clk_i = ~clk_i;

    //------------------------------------------------
    // helpers
    //------------------------------------------------
    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    function automatic logic [`DMA_TAGW-1:0] rand_tag();
        logic [31:0] r;
        r = $urandom;
        return r[`DMA_TAGW-1:0];
    endfunction

    function automatic logic [`DMA_DW-1:0] id_word(input logic [`DMA_IDW-1:0] id);
        return {{(`DMA_DW-`DMA_IDW){1'b0}}, id};
    endfunction

    function automatic dma_fe_pkg::dma_acc_req_t make_req(
        input logic [6:0]           funct7,
        input logic [4:0]           imm_cfg,
        input logic [`DMA_DW-1:0]   arga,
        input logic [`DMA_DW-1:0]   argb,
        input logic [`DMA_TAGW-1:0] tag
    );
        dma_fe_pkg::dma_acc_req_t r;
        r                     = '0;
        r.op.instr.opcode     = `DMA_OPCODE;
        r.op.instr.funct3     = 3'd0;
        r.op.instr.funct7     = funct7;
        r.op.instr.rd         = 5'd10;
        r.op.imm.imm_cfg      = imm_cfg;
        r.tag                 = tag;
        r.arga                = arga;
        r.argb                = argb;
        return r;
    endfunction

    // expected beats of one start in row order
    function automatic void predict_beats(input dma_fe_pkg::dma_twod_req_t req);
        dma_fe_pkg::dma_beat_t b;
        logic [`DMA_AW-1:0]    rows;
        logic [`DMA_AW-1:0]    r;
        logic [`DMA_AW-1:0]    src;
        logic [`DMA_AW-1:0]    dst;
        logic [`DMA_AW-1:0]    left;
        logic [`DMA_AW-1:0]    len;
        rows = (req.is_twod && (req.num_reps != '0)) ? req.num_reps : 1;
        for (r = 0; r < rows; r++) begin
            src  = req.src + r * req.stride_src;
            dst  = req.dst + r * req.stride_dst;
            left = req.num_bytes;
            while (left != '0) begin
                len   = (left > BEAT) ? BEAT : left;
                b.src = src;
                b.dst = dst;
                b.len = len[LW-1:0];
                exp_beats.push_back(b);
                src   = src + BEAT;
                dst   = dst + BEAT;
                left  = left - len;
            end
        end
    endfunction

    function automatic void push_resp(input logic [`DMA_TAGW-1:0] tag,
                                      input logic [`DMA_DW-1:0] data);
        dma_fe_pkg::dma_acc_resp_t p;
        p.tag  = tag;
        p.data = data;
        exp_resps.push_back(p);
    endfunction

    //------------------------------------------------
    // accelerator port tasks
    //------------------------------------------------
    task automatic wait_accept();
        int unsigned n;
        n = 0;
        @(negedge clk_i);
        while (!acc_qready_o) begin
            if (n == TIMEOUT) begin
                report_error("request was not accepted before the timeout");
            end
            n++;
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        acc_qvalid_i = 1'b0;
    endtask

    task automatic send_op(input dma_fe_pkg::dma_acc_req_t req);
        acc_req_i    = req;
        acc_qvalid_i = 1'b1;
        wait_accept();
    endtask

    task automatic write_reg(input logic [6:0] funct7, input logic [`DMA_DW-1:0] arga,
                             input logic [`DMA_DW-1:0] argb);
        case (funct7)
            `DMA_F7_SRC: cfg.src = arga;
            `DMA_F7_DST: cfg.dst = arga;
            `DMA_F7_STRD: begin
                cfg.stride_src = arga;
                cfg.stride_dst = argb;
            end
            `DMA_F7_REPS: cfg.num_reps = arga;
            default: begin
            end
        endcase
        send_op(make_req(funct7, 5'd0, arga, argb, rand_tag()));
    endtask

    // start with the immediate form or the register form
    task automatic start_xfer(input logic use_imm, input logic twod,
                              input logic [`DMA_AW-1:0] bytes);
        logic [`DMA_TAGW-1:0] tag;
        tag           = rand_tag();
        cfg.num_bytes = bytes;
        cfg.is_twod   = twod;
        predict_beats(cfg);
        push_resp(tag, id_word(exp_id));
        exp_id++;
        if (use_imm) begin
            send_op(make_req(`DMA_F7_STRTI, {4'd0, twod}, bytes, '0, tag));
        end else begin
            send_op(make_req(`DMA_F7_STRT, 5'd0, bytes, {{(`DMA_DW-1){1'b0}}, twod}, tag));
        end
    endtask

    task automatic query_status(input logic use_imm, input logic [1:0] sel,
                                input logic [`DMA_DW-1:0] exp_data);
        logic [`DMA_TAGW-1:0] tag;
        tag = rand_tag();
        push_resp(tag, exp_data);
        if (use_imm) begin
            send_op(make_req(`DMA_F7_STATI, {3'd0, sel}, '0, '0, tag));
        end else begin
            send_op(make_req(`DMA_F7_STAT, 5'd0, {{(`DMA_DW-2){1'b0}}, sel}, '0, tag));
        end
    endtask

    task automatic check_responses();
        dma_fe_pkg::dma_acc_resp_t exp_resp;
        dma_fe_pkg::dma_acc_resp_t got_resp;
        int unsigned               n;
        while (exp_resps.size() != 0) begin
            n = 0;
            while (got_resps.size() == 0) begin
                if (n == TIMEOUT) begin
                    report_error("no response arrived before the timeout");
                end
                n++;
                next_cycle();
            end
            exp_resp = exp_resps.pop_front();
            got_resp = got_resps.pop_front();
            assert (got_resp == exp_resp)
            else report_error($sformatf("Error: %s response expected %h actual %h",
                                        test_name, exp_resp, got_resp));
        end
    endtask

    task automatic wait_idle();
        int unsigned n;
        n = 0;
        while (dma_busy_o || (exp_beats.size() != 0)) begin
            if (n == TIMEOUT) begin
                report_error("transfer did not complete before the timeout");
            end
            n++;
            next_cycle();
        end
    endtask

    //------------------------------------------------
    // monitors sampled at the falling edge
    //------------------------------------------------
    always @(negedge clk_i) begin : resp_monitor
        if (rst_ni && acc_pvalid_o && acc_pready_i) begin
            got_resps.push_back(acc_resp_o);
        end
    end

    always @(negedge clk_i) begin : beat_check
        dma_fe_pkg::dma_beat_t exp_beat;
        if (rst_ni && beat_valid_o) begin
            assert (exp_beats.size() != 0)
            else report_error($sformatf("unexpected beat during %s", test_name));
            exp_beat = exp_beats.pop_front();
            assert (beat_o == exp_beat)
            else report_error($sformatf("Error: %s beat expected %h actual %h",
                                        test_name, exp_beat, beat_o));
        end
    end

    //------------------------------------------------
    // stimulus
    //------------------------------------------------
    initial begin : stimulus
        dma_fe_pkg::dma_acc_req_t req;
        logic [`DMA_TAGW-1:0]     tag;
        int unsigned              n;
        void'($urandom(32'h6d31_fce0));
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        acc_req_i    = '0;
        acc_qvalid_i = 1'b0;
        acc_pready_i = 1'b1;
        cfg          = '0;
        exp_id       = '0;
        test_name    = "reset";
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        next_cycle();

        test_name = "reset_status";
        assert (!dma_busy_o && !acc_pvalid_o && !beat_valid_o)
        else report_error($sformatf("Error: %s busy/pvalid/beat expected 000 actual %b%b%b",
                                    test_name, dma_busy_o, acc_pvalid_o, beat_valid_o));
        query_status(1'b0, `DMA_STAT_COMPLETED, '0);
        query_status(1'b0, `DMA_STAT_NEXT, '0);
        check_responses();

        test_name = "single_1d";
        write_reg(`DMA_F7_SRC, $urandom, '0);
        write_reg(`DMA_F7_DST, $urandom, '0);
        start_xfer(1'b0, 1'b0, $urandom_range(100, 1));
        check_responses();
        wait_idle();
        query_status(1'b0, `DMA_STAT_COMPLETED, id_word(exp_id));
        query_status(1'b0, `DMA_STAT_NEXT, id_word(exp_id));
        check_responses();

        // random strides and 1 to 4 rows
        test_name = "strided_2d";
        for (n = 0; n < 3; n++) begin
            write_reg(`DMA_F7_SRC, $urandom, '0);
            write_reg(`DMA_F7_DST, $urandom, '0);
            write_reg(`DMA_F7_STRD, $urandom, $urandom);
            write_reg(`DMA_F7_REPS, $urandom_range(4, 1), '0);
            start_xfer(1'b1, 1'b1, $urandom_range(40, 1));
            check_responses();
            wait_idle();
        end
        test_name = "zero_reps";
        write_reg(`DMA_F7_REPS, '0, '0);
        start_xfer(1'b1, 1'b1, $urandom_range(40, 1));
        check_responses();
        wait_idle();

        test_name = "back_to_back";
        write_reg(`DMA_F7_REPS, 32'd2, '0);
        start_xfer(1'b0, 1'b0, $urandom_range(30, 1));
        start_xfer(1'b0, 1'b1, $urandom_range(30, 1));
        start_xfer(1'b1, 1'b0, $urandom_range(30, 1));
        check_responses();
        wait_idle();

        // two responses fill the spill register and the third stalls
        test_name = "resp_backpressure";
        acc_pready_i = 1'b0;
        query_status(1'b0, `DMA_STAT_NEXT, id_word(exp_id));
        query_status(1'b1, `DMA_STAT_COMPLETED, id_word(exp_id));
        tag = rand_tag();
        req = make_req(`DMA_F7_STAT, 5'd0, {{(`DMA_DW-2){1'b0}}, `DMA_STAT_BUSY}, '0, tag);
        push_resp(tag, '0);
        acc_req_i    = req;
        acc_qvalid_i = 1'b1;
        repeat (8) begin
            @(negedge clk_i);
            assert (!acc_qready_o && acc_pvalid_o)
            else report_error($sformatf("Error: %s qready/pvalid expected 01 actual %b%b",
                                        test_name, acc_qready_o, acc_pvalid_o));
        end
        // the oldest response stays at the output while stalled
        assert (acc_resp_o == exp_resps[0])
        else report_error($sformatf("Error: %s held response expected %h actual %h",
                                    test_name, exp_resps[0], acc_resp_o));
        @(posedge clk_i);
        #1;
        acc_pready_i = 1'b1;
        wait_accept();
        check_responses();

        test_name = "busy_status";
        start_xfer(1'b0, 1'b0, 32'd512);
        check_responses();
        query_status(1'b1, `DMA_STAT_BUSY, 32'd1);
        check_responses();
        wait_idle();
        query_status(1'b1, `DMA_STAT_BUSY, '0);
        check_responses();

        next_cycle();
        test_name = "end_of_run";
        assert (got_resps.size() == 0)
        else report_error("responses were left over at the end of the run");
        $display("Test OK");
        $finish;
    end

endmodule
